/* files.f */
+incdir+hdl
hdl/tcdm_pkg.sv
hdl/tcdm_mux_static.sv
hdl/tcdm_arbiter.sv
hdl/tcdm_bank.sv
hdl/tcdm_subsystem.sv
verification/tcdm_chk.sv
verification/tcdm_tb.sv

/* hdl/tcdm_arbiter.sv */
// Two-port round-robin arbiter in front of a single TCDM bank.
// One outstanding response; owner_q steers it back to the winner.
// Request path is combinational, gnt comes straight from the bank.

`timescale 1ns/10ps
`default_nettype none

module tcdm_arbiter (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  tcdm_pkg::tcdm_req_t acc_req_i,
  output tcdm_pkg::tcdm_rsp_t acc_rsp_o,
  input  tcdm_pkg::tcdm_req_t core_req_i,
  output tcdm_pkg::tcdm_rsp_t core_rsp_o,
  output tcdm_pkg::tcdm_req_t bank_req_o,
  input  tcdm_pkg::tcdm_rsp_t bank_rsp_i
);

  tcdm_pkg::arb_owner_e prio_q;    // Port that wins a tie.
  tcdm_pkg::arb_owner_e prio_d;
  tcdm_pkg::arb_owner_e owner_q;   // Winner of the last grant.
  tcdm_pkg::arb_owner_e winner;    // Port forwarded this cycle.
  logic                 granted;   // Bank took the request.
  logic                 owner_rdy; // r_ready of the response owner.

  // ##################################################
  // Winner selection
  // ##################################################

  always_comb begin
    if (acc_req_i.req && core_req_i.req) begin
      winner = prio_q;  // Contention, pointer decides.
    end else if (core_req_i.req) begin
      winner = tcdm_pkg::OWNER_CORE;
    end else begin
      winner = tcdm_pkg::OWNER_ACC;  // Also the idle default.
    end
  end

  // Pointer flips away from whoever just won.
  assign prio_d = (winner == tcdm_pkg::OWNER_ACC) ? tcdm_pkg::OWNER_CORE
                                                  : tcdm_pkg::OWNER_ACC;

  assign granted = bank_rsp_i.gnt;

  // ##################################################
  // Request to the bank
  // ##################################################

  assign owner_rdy = (owner_q == tcdm_pkg::OWNER_CORE) ? core_req_i.r_ready
                                                       : acc_req_i.r_ready;

  always_comb begin
    if (winner == tcdm_pkg::OWNER_CORE) begin
      bank_req_o = core_req_i;
    end else begin
      bank_req_o = acc_req_i;
    end
    // Response side belongs to the previous winner.
    bank_req_o.r_ready = owner_rdy;
  end

  // ##################################################
  // Responses to the ports
  // ##################################################

  always_comb begin
    acc_rsp_o  = bank_rsp_i;  // r_data broadcast.
    core_rsp_o = bank_rsp_i;

    acc_rsp_o.gnt  = granted && (winner == tcdm_pkg::OWNER_ACC);
    core_rsp_o.gnt = granted && (winner == tcdm_pkg::OWNER_CORE);

    acc_rsp_o.r_valid  = bank_rsp_i.r_valid && (owner_q == tcdm_pkg::OWNER_ACC);
    core_rsp_o.r_valid = bank_rsp_i.r_valid && (owner_q == tcdm_pkg::OWNER_CORE);
  end

  // ##################################################
  // State
  // ##################################################

  // Both registers move only on a granted transfer.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_q  <= tcdm_pkg::OWNER_ACC;  // Accelerator first.
      owner_q <= tcdm_pkg::OWNER_ACC;
    end else if (granted) begin
      prio_q  <= prio_d;
      owner_q <= winner;  // Valid from the next cycle on.
    end
  end

endmodule

`default_nettype wire

/* hdl/tcdm_bank.sv */
// Single-port SRAM bank with byte enables and one response slot.
// Every granted request, read or write, yields one response.
// Write responses carry zero data. Memory content is not reset.

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_bank (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  tcdm_pkg::tcdm_req_t req_i,
  output tcdm_pkg::tcdm_rsp_t rsp_o
);

  localparam int unsigned BE_W  = `TCDM_DW / 8;              // Bytes per word.
  localparam int unsigned OFF_W = $clog2(BE_W);              // Byte offset bits.
  localparam int unsigned IDX_W = $clog2(`TCDM_NB_WORDS);    // Word index bits.

  logic [`TCDM_DW-1:0] mem_q [`TCDM_NB_WORDS];  // Storage array.
  logic [IDX_W-1:0]    idx;          // Word addressed this cycle.
  logic                slot_free;    // Response slot can take a new entry.
  logic                gnt;          // Request accepted.
  logic                is_read;
  logic                r_valid_q;    // Response slot full.
  logic [`TCDM_DW-1:0] r_data_q;     // Response payload.

  // ##################################################
  // Handshake
  // ##################################################

  assign idx     = req_i.add[OFF_W +: IDX_W];  // Drop the byte offset.
  assign is_read = (req_i.op == tcdm_pkg::OP_READ);

  // Slot is free if empty or drained this cycle.
  assign slot_free = !r_valid_q || req_i.r_ready;
  assign gnt       = req_i.req && slot_free;

  // ##################################################
  // Storage
  // ##################################################

  // Byte-masked write.
  always_ff @(posedge clk_i) begin
    if (gnt && !is_read) begin
      for (int unsigned b = 0; b < BE_W; b++) begin
        if (req_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  // ##################################################
  // Response slot
  // ##################################################

  // Payload, loaded on every grant.
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      r_data_q <= is_read ? mem_q[idx] : '0;  // Old word on a read.
    end
  end

  // Valid flag. Refill wins over drain.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else if (gnt) begin
      r_valid_q <= 1'b1;
    end else if (req_i.r_ready) begin
      r_valid_q <= 1'b0;  // Consumed, nothing new.
    end
  end

  assign rsp_o = '{
    gnt:     gnt,
    r_valid: r_valid_q,
    r_data:  r_data_q
  };

endmodule

`default_nettype wire

/* hdl/tcdm_defines.svh */
// Global sizes of the TCDM subsystem.
// TCDM_DW must be a multiple of 8; TCDM_NB_WORDS a power of two.
// TCDM_AW must cover the byte offset plus the word index.

`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

// ##################################################
// Data path
// ##################################################
`define TCDM_DW          32   // Data width in bits.
`define TCDM_AW          10   // Byte address width.

// ##################################################
// Bank and initiators
// ##################################################
`define TCDM_NB_WORDS    256  // Bank depth in words.
`define TCDM_NB_ACC_CHAN 2    // Alternate accelerator channels.

`endif

/* hdl/tcdm_mux_static.sv */
// Static N-to-1 mux for accelerator channels used strictly one at a time.
// sel_i may change only while no request or response is in flight.
// No arbitration here; an unselected channel simply waits.

`timescale 1ns/10ps
`default_nettype none

module tcdm_mux_static #(
  parameter  int unsigned NB_CHAN = 2,
  localparam int unsigned SEL_W   = (NB_CHAN > 1) ? $clog2(NB_CHAN) : 1
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic [SEL_W-1:0]    sel_i,
  input  tcdm_pkg::tcdm_req_t chan_req_i [NB_CHAN],
  output tcdm_pkg::tcdm_rsp_t chan_rsp_o [NB_CHAN],
  output tcdm_pkg::tcdm_req_t req_o,
  input  tcdm_pkg::tcdm_rsp_t rsp_i
);

  // ##################################################
  // Request path
  // ##################################################

  // Whole request of the selected channel, r_ready included.
  always_comb begin
    req_o = '0;  // Idle if sel_i points past the last channel.
    for (int unsigned ii = 0; ii < NB_CHAN; ii++) begin
      if (sel_i == ii) begin
        req_o = chan_req_i[ii];
      end
    end
  end

  // ##################################################
  // Response path
  // ##################################################

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan_rsp
    logic chan_sel;  // This channel owns the port.

    assign chan_sel = (sel_i == ii);

    // Handshakes only to the owner; data to all.
    assign chan_rsp_o[ii] = '{
      gnt:     rsp_i.gnt && chan_sel,
      r_valid: rsp_i.r_valid && chan_sel,
      r_data:  rsp_i.r_data
    };
  end

  // Select must be driven once out of reset.
  sel_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !$isunknown(sel_i)
  ) else $error("Accelerator select is unknown.");

endmodule

`default_nettype wire

/* hdl/tcdm_pkg.sv */
// Request/response types shared by every TCDM block.
// Widths come from the global defines; change them there only.
// op follows the wen convention: 1 is a read, 0 is a write.

`default_nettype none

`include "tcdm_defines.svh"

package tcdm_pkg;

  // ##################################################
  // Enums
  // ##################################################

  // Transfer opcode, active-low write enable.
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } tcdm_op_e;

  // Arbiter port identifier.
  typedef enum logic {
    OWNER_ACC  = 1'b0,  // Multiplexed accelerator port.
    OWNER_CORE = 1'b1   // Core port.
  } arb_owner_e;

  // ##################################################
  // Handshake structs
  // ##################################################

  // Initiator to target.
  typedef struct packed {
    logic                   req;      // Request strobe.
    tcdm_op_e               op;       // Read or write.
    logic [`TCDM_AW-1:0]    add;      // Byte address.
    logic [`TCDM_DW/8-1:0]  be;       // Byte enables.
    logic [`TCDM_DW-1:0]    data;     // Write data.
    logic                   r_ready;  // Response accept.
  } tcdm_req_t;

  // Target to initiator.
  typedef struct packed {
    logic                   gnt;      // Request accepted.
    logic                   r_valid;  // Response present.
    logic [`TCDM_DW-1:0]    r_data;   // Read data, zero on writes.
  } tcdm_rsp_t;

endpackage

`default_nettype wire

/* hdl/tcdm_subsystem.sv */
// TCDM subsystem: accelerator channels muxed statically, then
// arbitrated round-robin against the core onto one bank.
// acc_sel_i is quasi-static; change it only with the accelerator idle.

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_subsystem (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                acc_sel_i,
  input  tcdm_pkg::tcdm_req_t acc_req_i  [`TCDM_NB_ACC_CHAN],
  output tcdm_pkg::tcdm_rsp_t acc_rsp_o  [`TCDM_NB_ACC_CHAN],
  input  tcdm_pkg::tcdm_req_t core_req_i,
  output tcdm_pkg::tcdm_rsp_t core_rsp_o
);

  tcdm_pkg::tcdm_req_t acc_mux_req;  // Mux to arbiter.
  tcdm_pkg::tcdm_rsp_t acc_mux_rsp;
  tcdm_pkg::tcdm_req_t bank_req;     // Arbiter to bank.
  tcdm_pkg::tcdm_rsp_t bank_rsp;

  // ##################################################
  // Accelerator side
  // ##################################################

  tcdm_mux_static #(
    .NB_CHAN    ( `TCDM_NB_ACC_CHAN )
  ) i_acc_mux (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .sel_i      ( acc_sel_i   ),
    .chan_req_i ( acc_req_i   ),
    .chan_rsp_o ( acc_rsp_o   ),
    .req_o      ( acc_mux_req ),
    .rsp_i      ( acc_mux_rsp )
  );

  // ##################################################
  // Shared bank
  // ##################################################

  tcdm_arbiter i_arbiter (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .acc_req_i  ( acc_mux_req ),
    .acc_rsp_o  ( acc_mux_rsp ),
    .core_req_i ( core_req_i  ),
    .core_rsp_o ( core_rsp_o  ),
    .bank_req_o ( bank_req    ),
    .bank_rsp_i ( bank_rsp    )
  );

  tcdm_bank i_bank (
    .clk_i      ( clk_i    ),
    .rst_n_i    ( rst_n_i  ),
    .req_i      ( bank_req ),
    .rsp_o      ( bank_rsp )
  );

endmodule

`default_nettype wire

/* verification/tcdm_chk.sv */
// Protocol assertions for the TCDM subsystem, bound to its top level.
// Select stability uses the internal mux-to-arbiter link.

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_chk (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                acc_sel_i,
  input tcdm_pkg::tcdm_req_t acc_req_i [`TCDM_NB_ACC_CHAN],
  input tcdm_pkg::tcdm_rsp_t acc_rsp_i [`TCDM_NB_ACC_CHAN],
  input tcdm_pkg::tcdm_req_t core_req_i,
  input tcdm_pkg::tcdm_rsp_t core_rsp_i,
  input tcdm_pkg::tcdm_req_t mux_req_i,
  input tcdm_pkg::tcdm_rsp_t mux_rsp_i
);

  logic [`TCDM_NB_ACC_CHAN:0] gnt_vec;  // Core in the top bit.

  always_comb begin
    for (int ii = 0; ii < `TCDM_NB_ACC_CHAN; ii++) begin
      gnt_vec[ii] = acc_rsp_i[ii].gnt;
    end
    gnt_vec[`TCDM_NB_ACC_CHAN] = core_rsp_i.gnt;
  end

  // ##################################################
  // Response hold
  // ##################################################

  for (genvar ii = 0; ii < `TCDM_NB_ACC_CHAN; ii++) begin : gen_acc_hold
    acc_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      acc_rsp_i[ii].r_valid && !acc_req_i[ii].r_ready |=>
        acc_rsp_i[ii].r_valid && $stable(acc_rsp_i[ii].r_data)
    ) else $error("Accelerator response dropped or changed before r_ready.");
  end

  core_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_rsp_i.r_valid && !core_req_i.r_ready |=>
      core_rsp_i.r_valid && $stable(core_rsp_i.r_data)
  ) else $error("Core response dropped or changed before r_ready.");

  // At most one grant per cycle.
  one_gnt_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(gnt_vec)
  ) else $error("More than one port granted in the same cycle.");

  // Select moves only with the accelerator side idle.
  sel_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $changed(acc_sel_i) |->
      !$past(mux_req_i.req && !mux_rsp_i.gnt) && !$past(mux_rsp_i.gnt) &&
      !$past(mux_rsp_i.r_valid && !mux_req_i.r_ready)
  ) else $error("Accelerator select changed with a transfer pending.");

endmodule

bind tcdm_subsystem tcdm_chk chk_i (
  .clk_i      ( clk_i       ),
  .rst_n_i    ( rst_n_i     ),
  .acc_sel_i  ( acc_sel_i   ),
  .acc_req_i  ( acc_req_i   ),
  .acc_rsp_i  ( acc_rsp_o   ),
  .core_req_i ( core_req_i  ),
  .core_rsp_i ( core_rsp_o  ),
  .mux_req_i  ( acc_mux_req ),
  .mux_rsp_i  ( acc_mux_rsp )
);

`default_nettype wire

/* verification/tcdm_tb.sv */
// Table-driven testbench for the TCDM subsystem with a reference memory.
// Inputs change 2 ns after the rising edge, outputs are sampled at the falling edge.
// Reads only target addresses written earlier in the table.

`timescale 1ns/10ps
`default_nettype none

`include "tcdm_defines.svh"

module tcdm_tb;

  localparam int NB_TESTS  = 17;
  localparam int MAX_STALL = 5;
  localparam int HOLD_CYC  = 3;   // Cycles an unselected channel waits.
  localparam int WD_CYCLES = NB_TESTS * (MAX_STALL + 8) + 20;
  localparam int NONE = -1;
  localparam int ACC0 = 0;
  localparam int ACC1 = 1;
  localparam int CORE = 2;
  localparam int P_OFF = 0;       // Slot phases.
  localparam int P_REQ = 1;
  localparam int P_RSP = 2;
  localparam int P_DONE = 3;
  localparam int BE_W = `TCDM_DW / 8;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  logic                acc_sel_i;
  tcdm_pkg::tcdm_req_t acc_req [`TCDM_NB_ACC_CHAN];
  tcdm_pkg::tcdm_rsp_t acc_rsp [`TCDM_NB_ACC_CHAN];
  tcdm_pkg::tcdm_req_t core_req;
  tcdm_pkg::tcdm_rsp_t core_rsp;

  // Stimulus table.
  string               t_name  [NB_TESTS];
  int                  t_port  [NB_TESTS];
  int                  t_port2 [NB_TESTS];  // Concurrent port or NONE.
  logic                t_sel   [NB_TESTS];
  tcdm_pkg::tcdm_op_e  t_op    [NB_TESTS];
  logic [`TCDM_AW-1:0] t_add   [NB_TESTS];
  logic [`TCDM_AW-1:0] t_add2  [NB_TESTS];
  logic [BE_W-1:0]     t_be    [NB_TESTS];
  logic [`TCDM_DW-1:0] t_data  [NB_TESTS];
  int                  t_stall [NB_TESTS];
  int                  n_tests;

  logic [`TCDM_DW-1:0]  ref_mem [`TCDM_NB_WORDS];  // Reference model.
  tcdm_pkg::arb_owner_e prio;                      // Expected tie winner.

  always #10 clk_i = ~clk_i;

  tcdm_subsystem dut_i (
    .clk_i      ( clk_i     ),
    .rst_n_i    ( rst_n_i   ),
    .acc_sel_i  ( acc_sel_i ),
    .acc_req_i  ( acc_req   ),
    .acc_rsp_o  ( acc_rsp   ),
    .core_req_i ( core_req  ),
    .core_rsp_o ( core_rsp  )
  );

  // ##################################################
  // Port access and checks
  // ##################################################

  function automatic tcdm_pkg::tcdm_rsp_t port_rsp(input int p);
    if (p == CORE) return core_rsp;
    return acc_rsp[p];
  endfunction

  function automatic string port_name(input int p);
    if (p == CORE) return "core";
    return (p == ACC0) ? "acc0" : "acc1";
  endfunction

  function automatic logic port_selected(input int p);
    return (p == CORE) || (p == int'(acc_sel_i));
  endfunction

  function automatic tcdm_pkg::arb_owner_e port_owner(input int p);
    return (p == CORE) ? tcdm_pkg::OWNER_CORE : tcdm_pkg::OWNER_ACC;
  endfunction

  task automatic drive_port(input int p, input tcdm_pkg::tcdm_req_t r);
    if (p == CORE) core_req = r;
    else acc_req[p] = r;
  endtask

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "Stopped at the first failing check.");
  endtask

  // Handshake bits only; data has its own task.
  task automatic check_rsp(input string name, input int p,
                           input tcdm_pkg::tcdm_rsp_t exp, input tcdm_pkg::tcdm_rsp_t act);
    if (act.gnt !== exp.gnt || act.r_valid !== exp.r_valid) begin
      $display("CHECK FAILED %s: port %s expected gnt=%0b r_valid=%0b, actual gnt=%0b r_valid=%0b",
               name, port_name(p), exp.gnt, exp.r_valid, act.gnt, act.r_valid);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input logic [`TCDM_DW-1:0] exp,
                            input logic [`TCDM_DW-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected r_data=%h, actual r_data=%h", name, exp, act);
      stop_run();
    end
  endtask

  // Grant seen by the model. Read sees the old word.
  task automatic model_access(input tcdm_pkg::tcdm_req_t r, output logic [`TCDM_DW-1:0] rd);
    logic [`TCDM_AW-3:0] idx;
    idx = r.add[`TCDM_AW-1:2];
    rd  = (r.op == tcdm_pkg::OP_READ) ? ref_mem[idx] : '0;
    if (r.op == tcdm_pkg::OP_WRITE) begin
      for (int b = 0; b < BE_W; b++) begin
        if (r.be[b]) ref_mem[idx][8*b +: 8] = r.data[8*b +: 8];
      end
    end
  endtask

  task automatic add_test(input string name, input int port, input int port2, input logic sel,
                          input tcdm_pkg::tcdm_op_e op, input logic [`TCDM_AW-1:0] add,
                          input logic [`TCDM_AW-1:0] add2, input logic [BE_W-1:0] be,
                          input logic [`TCDM_DW-1:0] data, input int stall);
    t_name[n_tests]  = name;
    t_port[n_tests]  = port;
    t_port2[n_tests] = port2;
    t_sel[n_tests]   = sel;
    t_op[n_tests]    = op;
    t_add[n_tests]   = add;
    t_add2[n_tests]  = add2;
    t_be[n_tests]    = be;
    t_data[n_tests]  = data;
    t_stall[n_tests] = stall;
    n_tests++;
  endtask

  // ##################################################
  // Transfer engine
  // ##################################################

  task automatic run_test(input int t);
    int                  s_port [2];
    tcdm_pkg::tcdm_req_t s_req  [2];
    int                  phase  [2];
    int                  stall_left [2];
    logic [`TCDM_DW-1:0] s_exp  [2];
    tcdm_pkg::tcdm_rsp_t exp_rsp;
    tcdm_pkg::tcdm_rsp_t act;
    tcdm_pkg::tcdm_req_t r;
    logic                busy;
    logic                drained;
    int                  win;
    int                  hold;
    s_port[0] = t_port[t];
    s_port[1] = t_port2[t];
    s_req[0]  = '{1'b1, t_op[t], t_add[t], t_be[t], t_data[t], 1'b0};
    s_req[1]  = '{1'b1, t_op[t], t_add2[t], '1, ~t_data[t], 1'b0};
    phase[0]  = P_REQ;
    phase[1]  = (t_port2[t] == NONE) ? P_OFF : P_REQ;
    stall_left[0] = t_stall[t];
    stall_left[1] = 0;
    hold = 0;
    @(posedge clk_i);
    #2;
    acc_sel_i = t_sel[t];
    while (phase[0] != P_DONE || phase[1] == P_REQ || phase[1] == P_RSP) begin
      for (int s = 0; s < 2; s++) begin
        if (phase[s] != P_OFF) begin
          r = s_req[s];
          r.req = (phase[s] == P_REQ);
          r.r_ready = (phase[s] != P_DONE) && (stall_left[s] == 0);
          drive_port(s_port[s], (phase[s] == P_DONE) ? '0 : r);
        end
      end
      @(negedge clk_i);
      // Expected grant from the slot state and the pointer.
      busy = 1'b0;
      drained = 1'b0;
      win = NONE;
      for (int s = 0; s < 2; s++) begin
        if (phase[s] == P_RSP) begin
          busy = 1'b1;
          drained = (stall_left[s] == 0);
        end
        if (phase[s] == P_REQ && port_selected(s_port[s])) begin
          if (win == NONE || port_owner(s_port[s]) == prio) win = s;
        end
      end
      if (busy && !drained) win = NONE;  // Slot full, stalled.
      for (int p = 0; p <= CORE; p++) begin
        exp_rsp = '0;
        exp_rsp.gnt = (win != NONE) && (s_port[win] == p);
        for (int s = 0; s < 2; s++) begin
          if (phase[s] == P_RSP && s_port[s] == p) exp_rsp.r_valid = 1'b1;
        end
        act = port_rsp(p);
        check_rsp(t_name[t], p, exp_rsp, act);
      end
      for (int s = 0; s < 2; s++) begin
        if (phase[s] == P_RSP) begin
          act = port_rsp(s_port[s]);
          check_data(t_name[t], s_exp[s], act.r_data);
          if (stall_left[s] == 0) phase[s] = P_DONE;
          else stall_left[s]--;
        end
      end
      if (win != NONE) begin
        model_access(s_req[win], s_exp[win]);
        phase[win] = P_RSP;
        prio = (port_owner(s_port[win]) == tcdm_pkg::OWNER_ACC) ? tcdm_pkg::OWNER_CORE
                                                                : tcdm_pkg::OWNER_ACC;
      end
      if (phase[0] == P_REQ && !port_selected(s_port[0])) hold++;
      @(posedge clk_i);
      #2;
      if (hold >= HOLD_CYC && phase[0] == P_REQ && !port_selected(s_port[0])) begin
        acc_sel_i = (s_port[0] == ACC1);  // Hand the mux to the waiting channel.
      end
    end
    for (int s = 0; s < 2; s++) begin
      if (phase[s] != P_OFF) drive_port(s_port[s], '0);
    end
  endtask

  // ##################################################
  // Main sequence
  // ##################################################

  initial begin
    void'($urandom(32'h70b6));
    rst_n_i     = 1'b0;
    acc_sel_i   = 1'b0;
    acc_req[0]  = '0;
    acc_req[1]  = '0;
    core_req    = '0;
    n_tests     = 0;
    prio        = tcdm_pkg::OWNER_ACC;
    add_test("pair_write", ACC0, CORE, 1'b0, tcdm_pkg::OP_WRITE, 10'h010, 10'h020, 4'hf,
             $urandom, 0);
    add_test("pair_read", ACC0, CORE, 1'b0, tcdm_pkg::OP_READ, 10'h010, 10'h020, 4'hf, 0, 0);
    add_test("acc0_write", ACC0, NONE, 1'b0, tcdm_pkg::OP_WRITE, 10'h040, 0, 4'hf,
             32'hc0ff_ee01, 0);
    add_test("acc0_read", ACC0, NONE, 1'b0, tcdm_pkg::OP_READ, 10'h040, 0, 4'hf, 0, 0);
    add_test("acc1_write", ACC1, NONE, 1'b1, tcdm_pkg::OP_WRITE, 10'h044, 0, 4'hf, $urandom, 0);
    add_test("acc1_read", ACC1, NONE, 1'b1, tcdm_pkg::OP_READ, 10'h044, 0, 4'hf, 0, 0);
    add_test("unsel_acc1_write", ACC1, NONE, 1'b0, tcdm_pkg::OP_WRITE, 10'h048, 0, 4'hf,
             $urandom, 0);
    add_test("acc1_read_back", ACC1, NONE, 1'b1, tcdm_pkg::OP_READ, 10'h048, 0, 4'hf, 0, 0);
    add_test("acc0_be_0101", ACC0, NONE, 1'b0, tcdm_pkg::OP_WRITE, 10'h040, 0, 4'b0101,
             $urandom, 0);
    add_test("acc0_be_read", ACC0, NONE, 1'b0, tcdm_pkg::OP_READ, 10'h040, 0, 4'hf, 0, 0);
    add_test("core_be_1000", CORE, NONE, 1'b0, tcdm_pkg::OP_WRITE, 10'h044, 0, 4'b1000,
             $urandom, 0);
    add_test("core_be_read", CORE, NONE, 1'b0, tcdm_pkg::OP_READ, 10'h044, 0, 4'hf, 0, 0);
    add_test("pair_acc1_write", ACC1, CORE, 1'b1, tcdm_pkg::OP_WRITE, 10'h100, 10'h104, 4'hf,
             $urandom, 0);
    add_test("pair_acc1_read", ACC1, CORE, 1'b1, tcdm_pkg::OP_READ, 10'h100, 10'h104, 4'hf,
             0, 0);
    // Core waits behind the stalled accelerator response.
    add_test("stall_acc0_read", ACC0, CORE, 1'b0, tcdm_pkg::OP_READ, 10'h040, 10'h020, 4'hf,
             0, MAX_STALL);
    add_test("stall_core_write", CORE, NONE, 1'b0, tcdm_pkg::OP_WRITE, 10'h3fc, 0, 4'hf,
             $urandom, 3);
    add_test("core_read_top", CORE, NONE, 1'b0, tcdm_pkg::OP_READ, 10'h3fc, 0, 4'hf, 0, 0);

    repeat (4) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    // Idle outputs before any request.
    repeat (3) begin
      @(negedge clk_i);
      for (int p = 0; p <= CORE; p++) check_rsp("reset_idle", p, '0, port_rsp(p));
    end
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Watchdog.
  initial begin
    repeat (WD_CYCLES) @(posedge clk_i);
    $display("Watchdog expired: the tests did not finish in the expected time.");
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation timed out.");
  end

endmodule

`default_nettype wire
